// ==== Bender.yml ====
package:
  name: simd_instr_decoder

sources:
  - include_dirs:
      - src
    files:
      - src/simd_decode_pkg.sv
      - src/operand_source_decoder.sv
      - src/alu_opcode_decoder.sv
      - src/simd_instr_decoder.sv
  - target: test
    include_dirs:
      - src
      - test
    files:
      - test/simd_instr_decoder_tb.sv

// ==== sim.f ====
+incdir+src
+incdir+test
src/simd_decode_pkg.sv
src/operand_source_decoder.sv
src/alu_opcode_decoder.sv
src/simd_instr_decoder.sv
test/simd_instr_decoder_tb.sv

// ==== src/alu_opcode_decoder.sv ====
`timescale 1ns/10ps
`include "simd_decode_consts.svh"

module alu_opcode_decoder (
  input  logic [`OPCODE_W-1:0]   opcode,
  input  logic [`SRC_ADDR_W-1:0] sgpr_dest_addr,
  output logic                   vcc_wr_en,
  output logic                   vgpr_wr_en,
  output logic                   sgpr_wr_en
);

  import simd_decode_pkg::*;

  logic [`FMT_MSB-`FMT_LSB:0] fmt_field;
  logic [`OP_MSB-`OP_LSB:0]   op_field;
  fmt_e                       fmt;
  wr_class_e                  wr_class;
  logic                       tbl_vcc;
  logic                       tbl_sgpr;
  logic                       dest_is_vcc;
  logic                       dest_is_sgpr;

  // Integer compares, same numbers in VOPC and VOP3A
  function automatic logic is_cmp_op(input logic [`OP_MSB-`OP_LSB:0] op);
    return op inside {[`OP_V_CMP_F_I32 : `OP_V_CMP_TRU_I32],
                      [`OP_V_CMP_F_U32 : `OP_V_CMP_TRU_U32]};
  endfunction

  assign fmt_field = opcode[`FMT_MSB:`FMT_LSB];
  assign op_field  = opcode[`OP_MSB:`OP_LSB];

  always_comb
  begin
    case (fmt_field)
      `FMT_VOP1:  fmt = FMT_VOP1;
      `FMT_VOP2:  fmt = FMT_VOP2;
      `FMT_VOPC:  fmt = FMT_VOPC;
      `FMT_VOP3A: fmt = FMT_VOP3A;
      default:    fmt = FMT_OTHER;
    endcase
  end

  always_comb
  begin
    wr_class = WR_NONE;
    case (fmt)
      FMT_VOP1:
      begin
        if (op_field == `OP_V_MOV_B32)
          wr_class = WR_VGPR;
      end
      FMT_VOP2:
      begin
        case (op_field)
          `OP_V_CNDMASK_B32,
          `OP_V_MUL_I32_I24,
          `OP_V_MAX_I32,
          `OP_V_MIN_U32,
          `OP_V_MAX_U32,
          `OP_V_LSHRREV_B32,
          `OP_V_LSHLREV_B32,
          `OP_V_AND_B32,
          `OP_V_OR_B32:   wr_class = WR_VGPR;
          `OP_V_ADD_I32,
          `OP_V_SUB_I32,
          `OP_V_ADDC_U32: wr_class = WR_VGPR_VCC;  // Carry written to VCC
          default:        wr_class = WR_NONE;
        endcase
      end
      FMT_VOPC:
      begin
        if (is_cmp_op(op_field))
          wr_class = WR_VCC;
      end
      FMT_VOP3A:
      begin
        case (op_field)
          `OP_V3_MUL_I32_I24,
          `OP_V3_MIN_U32,
          `OP_V3_MAX_U32,
          `OP_V3_AND_B32,
          `OP_V3_BFE_U32,
          `OP_V3_BFI_B32,
          `OP_V3_MUL_LO_U32,
          `OP_V3_MUL_HI_U32,
          `OP_V3_MUL_LO_I32: wr_class = WR_VGPR;
          default:
          begin
            if (is_cmp_op(op_field))
              wr_class = WR_VCC_SGPR;  // Result may land in an SGPR pair
          end
        endcase
      end
      default:
      begin
        wr_class = WR_NONE;
      end
    endcase
  end

  always_comb
  begin
    case (wr_class)
      WR_VGPR:     {vgpr_wr_en, tbl_vcc, tbl_sgpr} = 3'b100;
      WR_VGPR_VCC: {vgpr_wr_en, tbl_vcc, tbl_sgpr} = 3'b110;
      WR_VCC:      {vgpr_wr_en, tbl_vcc, tbl_sgpr} = 3'b010;
      WR_VCC_SGPR: {vgpr_wr_en, tbl_vcc, tbl_sgpr} = 3'b011;
      default:     {vgpr_wr_en, tbl_vcc, tbl_sgpr} = 3'b000;
    endcase
  end

  // VOP3A destination field picks VCC or an SGPR
  assign dest_is_vcc  = (sgpr_dest_addr == `ADDR_VCC_LO);
  assign dest_is_sgpr = (sgpr_dest_addr[`SRC_ADDR_W-1 -: 3] == 3'b110);

  always_comb
  begin
    if (fmt == FMT_VOP3A && dest_is_vcc)
    begin
      vcc_wr_en  = 1'b1;
      sgpr_wr_en = 1'b0;
    end
    else if (fmt == FMT_VOP3A && dest_is_sgpr)
    begin
      vcc_wr_en  = 1'b0;
      sgpr_wr_en = 1'b1;
    end
    else
    begin
      vcc_wr_en  = tbl_vcc;
      sgpr_wr_en = tbl_sgpr;
    end
  end

endmodule

// ==== src/operand_source_decoder.sv ====
`timescale 1ns/10ps
`include "simd_decode_consts.svh"

module operand_source_decoder (
  input  logic [`SRC_ADDR_W-1:0]    src_addr,
  output simd_decode_pkg::src_sel_e src_sel,
  output logic                      vgpr_rd_en
);

  import simd_decode_pkg::*;

  logic [1:0] region;   // Top two address bits
  logic       sgpr_hit;

  assign region   = src_addr[`SRC_ADDR_W-1 -: 2];
  assign sgpr_hit = (src_addr[`SRC_ADDR_W-1 -: 3] == 3'b110);

  // First matching rule wins, literal sits inside the 01 region
  always_comb
  begin
    vgpr_rd_en = 1'b0;
    if (src_addr == `ADDR_LITERAL)
    begin
      src_sel = SRC_LITERAL;
    end
    else if (region == 2'b00)
    begin
      src_sel = SRC_CONST;
    end
    else if (region == 2'b10)
    begin
      src_sel    = SRC_VGPR;
      vgpr_rd_en = 1'b1;   // Only case that reads the VGPR file
    end
    else if (sgpr_hit)
    begin
      src_sel = SRC_SGPR;
    end
    else
    begin
      case (src_addr)
        `ADDR_VCC_LO:  src_sel = SRC_VCC_LO;
        `ADDR_VCC_HI:  src_sel = SRC_VCC_HI;
        `ADDR_M0:      src_sel = SRC_M0;
        `ADDR_EXEC_LO: src_sel = SRC_EXEC_LO;
        `ADDR_EXEC_HI: src_sel = SRC_EXEC_HI;
        `ADDR_VCCZ:    src_sel = SRC_VCCZ;
        `ADDR_EXECZ:   src_sel = SRC_EXECZ;
        `ADDR_SCC:     src_sel = SRC_SCC;
        default:       src_sel = SRC_INVALID;  // Rest of 01 and 111 regions
      endcase
    end
  end

endmodule

// ==== src/simd_decode_consts.svh ====
`ifndef SIMD_DECODE_CONSTS_SVH
`define SIMD_DECODE_CONSTS_SVH

`define SRC_ADDR_W 12  // Source and destination address
`define OPCODE_W   32  // Instruction word
`define MUX_SEL_W  4   // Source mux select

`define FMT_MSB 31
`define FMT_LSB 24
`define OP_MSB  11
`define OP_LSB  0

`define FMT_VOP1  8'h01
`define FMT_VOP2  8'h02
`define FMT_VOPC  8'h04
`define FMT_VOP3A 8'h08

`define OP_V_MOV_B32       12'h001  // VOP1
`define OP_V_CNDMASK_B32   12'h000  // VOP2 from here
`define OP_V_MUL_I32_I24   12'h009
`define OP_V_MAX_I32       12'h012
`define OP_V_MIN_U32       12'h013
`define OP_V_MAX_U32       12'h014
`define OP_V_LSHRREV_B32   12'h016
`define OP_V_LSHLREV_B32   12'h01A
`define OP_V_AND_B32       12'h01B
`define OP_V_OR_B32        12'h01C
`define OP_V_ADD_I32       12'h025
`define OP_V_SUB_I32       12'h026
`define OP_V_ADDC_U32      12'h028
`define OP_V_CMP_F_I32     12'h080  // Compares, VOPC and VOP3A
`define OP_V_CMP_TRU_I32   12'h087
`define OP_V_CMP_F_U32     12'h0C0
`define OP_V_CMP_TRU_U32   12'h0C7
`define OP_V3_MUL_I32_I24  12'h109  // VOP3A only from here
`define OP_V3_MIN_U32      12'h113
`define OP_V3_MAX_U32      12'h114
`define OP_V3_AND_B32      12'h11B
`define OP_V3_BFE_U32      12'h148
`define OP_V3_BFI_B32      12'h14A
`define OP_V3_MUL_LO_U32   12'h169
`define OP_V3_MUL_HI_U32   12'h16A
`define OP_V3_MUL_LO_I32   12'h16B

`define ADDR_LITERAL 12'h7FF
`define ADDR_VCC_LO  12'hE01
`define ADDR_VCC_HI  12'hE02
`define ADDR_M0      12'hE04
`define ADDR_EXEC_LO 12'hE08
`define ADDR_EXEC_HI 12'hE10
`define ADDR_VCCZ    12'hE20
`define ADDR_EXECZ   12'hE40
`define ADDR_SCC     12'hE80

`endif

// ==== src/simd_decode_pkg.sv ====
`include "simd_decode_consts.svh"

package simd_decode_pkg;

  // Value equals the format byte of the instruction word
  typedef enum logic [`FMT_MSB-`FMT_LSB:0] {
    FMT_OTHER = 8'h00,  // Any unknown format byte
    FMT_VOP1  = `FMT_VOP1,
    FMT_VOP2  = `FMT_VOP2,
    FMT_VOPC  = `FMT_VOPC,
    FMT_VOP3A = `FMT_VOP3A
  } fmt_e;

  typedef enum logic [`MUX_SEL_W-1:0] {
    SRC_LITERAL = 4'd0,
    SRC_CONST   = 4'd1,   // Inline constant
    SRC_VGPR    = 4'd2,
    SRC_SGPR    = 4'd3,
    SRC_VCC_LO  = 4'd4,
    SRC_VCC_HI  = 4'd5,
    SRC_M0      = 4'd6,
    SRC_EXEC_LO = 4'd7,
    SRC_EXEC_HI = 4'd8,
    SRC_VCCZ    = 4'd9,
    SRC_EXECZ   = 4'd10,
    SRC_SCC     = 4'd11,
    SRC_INVALID = 4'd15   // Unmapped address
  } src_sel_e;

  typedef enum logic [2:0] {
    WR_NONE     = 3'd0,
    WR_VGPR     = 3'd1,
    WR_VGPR_VCC = 3'd2,   // Carry out to VCC
    WR_VCC      = 3'd3,   // VOPC compare
    WR_VCC_SGPR = 3'd4    // VOP3A compare
  } wr_class_e;

endpackage

// ==== src/simd_instr_decoder.sv ====
`timescale 1ns/10ps
`include "simd_decode_consts.svh"

module simd_instr_decoder (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic [`SRC_ADDR_W-1:0]    src1_addr,
  input  logic [`SRC_ADDR_W-1:0]    src2_addr,
  input  logic [`SRC_ADDR_W-1:0]    src3_addr,
  input  logic [`OPCODE_W-1:0]      opcode,
  input  logic [`SRC_ADDR_W-1:0]    sgpr_dest_addr,
  output simd_decode_pkg::src_sel_e src1_sel,
  output simd_decode_pkg::src_sel_e src2_sel,
  output simd_decode_pkg::src_sel_e src3_sel,
  output logic                      vgpr_src1_rd_en,
  output logic                      vgpr_src2_rd_en,
  output logic                      vgpr_src3_rd_en,
  output logic                      vcc_wr_en,
  output logic                      vgpr_wr_en,
  output logic                      sgpr_wr_en
);

  import simd_decode_pkg::*;

  src_sel_e dec_src1_sel;   // Combinational decode results
  src_sel_e dec_src2_sel;
  src_sel_e dec_src3_sel;
  logic     dec_src1_rd_en;
  logic     dec_src2_rd_en;
  logic     dec_src3_rd_en;
  logic     dec_vcc_wr_en;
  logic     dec_vgpr_wr_en;
  logic     dec_sgpr_wr_en;

  operand_source_decoder i_src1_dec (
    .src_addr   (src1_addr),
    .src_sel    (dec_src1_sel),
    .vgpr_rd_en (dec_src1_rd_en)
  );

  operand_source_decoder i_src2_dec (
    .src_addr   (src2_addr),
    .src_sel    (dec_src2_sel),
    .vgpr_rd_en (dec_src2_rd_en)
  );

  operand_source_decoder i_src3_dec (
    .src_addr   (src3_addr),
    .src_sel    (dec_src3_sel),
    .vgpr_rd_en (dec_src3_rd_en)
  );

  alu_opcode_decoder i_op_dec (
    .opcode         (opcode),
    .sgpr_dest_addr (sgpr_dest_addr),
    .vcc_wr_en      (dec_vcc_wr_en),
    .vgpr_wr_en     (dec_vgpr_wr_en),
    .sgpr_wr_en     (dec_sgpr_wr_en)
  );

  // Single stage into the next pipeline register, one decode per cycle
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      src1_sel        <= SRC_INVALID;  // Nothing selected out of reset
      src2_sel        <= SRC_INVALID;
      src3_sel        <= SRC_INVALID;
      vgpr_src1_rd_en <= 1'b0;
      vgpr_src2_rd_en <= 1'b0;
      vgpr_src3_rd_en <= 1'b0;
      vcc_wr_en       <= 1'b0;
      vgpr_wr_en      <= 1'b0;
      sgpr_wr_en      <= 1'b0;
    end
    else
    begin
      src1_sel        <= dec_src1_sel;
      src2_sel        <= dec_src2_sel;
      src3_sel        <= dec_src3_sel;
      vgpr_src1_rd_en <= dec_src1_rd_en;
      vgpr_src2_rd_en <= dec_src2_rd_en;
      vgpr_src3_rd_en <= dec_src3_rd_en;
      vcc_wr_en       <= dec_vcc_wr_en;
      vgpr_wr_en      <= dec_vgpr_wr_en;
      sgpr_wr_en      <= dec_sgpr_wr_en;
    end
  end

endmodule

// ==== test/decode_ref.svh ====
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

`include "simd_decode_consts.svh"

// Expected mux select for one source address, first matching rule applies
function automatic src_sel_e ref_src_decode(input logic [`SRC_ADDR_W-1:0] addr);
  if (addr == `ADDR_LITERAL)
    return SRC_LITERAL;
  if (addr[11:10] == 2'b00)
    return SRC_CONST;
  if (addr[11:10] == 2'b10)
    return SRC_VGPR;
  if (addr[11:9] == 3'b110)
    return SRC_SGPR;
  case (addr)
    `ADDR_VCC_LO:  return SRC_VCC_LO;
    `ADDR_VCC_HI:  return SRC_VCC_HI;
    `ADDR_M0:      return SRC_M0;
    `ADDR_EXEC_LO: return SRC_EXEC_LO;
    `ADDR_EXEC_HI: return SRC_EXEC_HI;
    `ADDR_VCCZ:    return SRC_VCCZ;
    `ADDR_EXECZ:   return SRC_EXECZ;
    `ADDR_SCC:     return SRC_SCC;
    default:       return SRC_INVALID;
  endcase
endfunction

// Expected write enables packed as {vcc, vgpr, sgpr}
function automatic logic [2:0] ref_wr_decode(input logic [`OPCODE_W-1:0] word,
                                             input logic [`SRC_ADDR_W-1:0] dest);
  logic [7:0]  fmt;
  logic [11:0] op;
  logic        cmp;
  logic        vcc;
  logic        vgpr;
  logic        sgpr;
  fmt  = word[`FMT_MSB:`FMT_LSB];
  op   = word[`OP_MSB:`OP_LSB];
  cmp  = (op >= 12'h080 && op <= 12'h087) || (op >= 12'h0C0 && op <= 12'h0C7);
  vcc  = 1'b0;
  vgpr = 1'b0;
  sgpr = 1'b0;
  if (fmt == `FMT_VOP1)
    vgpr = (op == 12'h001);
  else if (fmt == `FMT_VOP2)
  begin
    vgpr = op inside {12'h000, 12'h009, 12'h012, 12'h013, 12'h014, 12'h016, 12'h01A,
                      12'h01B, 12'h01C, 12'h025, 12'h026, 12'h028};
    vcc  = op inside {12'h025, 12'h026, 12'h028};  // Carry out
  end
  else if (fmt == `FMT_VOPC)
    vcc = cmp;
  else if (fmt == `FMT_VOP3A)
  begin
    vgpr = op inside {12'h109, 12'h113, 12'h114, 12'h11B, 12'h148, 12'h14A,
                      12'h169, 12'h16A, 12'h16B};
    vcc  = cmp;
    sgpr = cmp;
    if (dest == `ADDR_VCC_LO)
    begin
      vcc  = 1'b1;  // Override to VCC
      sgpr = 1'b0;
    end
    else if (dest[11:9] == 3'b110)
    begin
      vcc  = 1'b0;  // Override to an SGPR
      sgpr = 1'b1;
    end
  end
  return {vcc, vgpr, sgpr};
endfunction

`endif

// ==== test/simd_instr_decoder_tb.sv ====
`timescale 1ns/10ps
`include "simd_decode_consts.svh"

module simd_instr_decoder_tb;

  import simd_decode_pkg::*;

  `include "decode_ref.svh"

  localparam int RAND_PER_REGION = 8;
  localparam int N_SRC       = 9 + 4 * RAND_PER_REGION;
  localparam int N_TABLE     = 54;
  localparam int N_OVERRIDE  = 20;
  localparam int N_UNKNOWN   = 48;
  localparam int N_B2B       = 32;
  localparam int NUM_VECTORS = N_SRC + N_TABLE + N_OVERRIDE + N_UNKNOWN + N_B2B;

  localparam logic [11:0] SPECIAL_ADDRS [0:8] = '{`ADDR_LITERAL, `ADDR_VCC_LO,
    `ADDR_VCC_HI, `ADDR_M0, `ADDR_EXEC_LO, `ADDR_EXEC_HI, `ADDR_VCCZ, `ADDR_EXECZ, `ADDR_SCC};
  localparam logic [11:0] VOP2_OPS [0:11] = '{12'h000, 12'h009, 12'h012, 12'h013,
    12'h014, 12'h016, 12'h01A, 12'h01B, 12'h01C, 12'h025, 12'h026, 12'h028};
  localparam logic [11:0] VOP3_OPS [0:8] = '{12'h109, 12'h113, 12'h114, 12'h11B,
    12'h148, 12'h14A, 12'h169, 12'h16A, 12'h16B};
  localparam logic [11:0] OVR_DESTS [0:3] = '{`ADDR_VCC_LO, 12'hC00, 12'hC5A, 12'hDFF};
  localparam logic [31:0] OVR_WORDS [0:4] = '{32'h0800_0080, 32'h0800_00C5,
    32'h0800_011B, 32'h0800_016A, 32'h0400_0084};  // Last one is a VOPC compare
  localparam logic [31:0] UNK_WORDS [0:7] = '{32'h0100_0002, 32'h0200_0030,
    32'h0400_0088, 32'h0400_00BF, 32'h0800_0200, 32'h0800_0200, 32'h1000_0025,
    32'h0000_0001};
  localparam logic [11:0] UNK_DESTS [0:7] = '{12'h000, 12'h000, 12'h000, 12'h000,
    12'h000, `ADDR_VCC_LO, 12'hC10, 12'h000};

  logic        clk;
  logic        arst_n;
  logic [11:0] src1_addr;
  logic [11:0] src2_addr;
  logic [11:0] src3_addr;
  logic [31:0] opcode;
  logic [11:0] sgpr_dest_addr;
  src_sel_e    src1_sel;
  src_sel_e    src2_sel;
  src_sel_e    src3_sel;
  logic        vgpr_src1_rd_en;
  logic        vgpr_src2_rd_en;
  logic        vgpr_src3_rd_en;
  logic        vcc_wr_en;
  logic        vgpr_wr_en;
  logic        sgpr_wr_en;

  integer      seed = 32'h1292f232;
  logic        chk_en;      // Current inputs are a vector to check
  int          err_count;
  int          vec_count;
  int          tests_run;

  simd_instr_decoder i_dut (
    .clk             (clk),
    .arst_n          (arst_n),
    .src1_addr       (src1_addr),
    .src2_addr       (src2_addr),
    .src3_addr       (src3_addr),
    .opcode          (opcode),
    .sgpr_dest_addr  (sgpr_dest_addr),
    .src1_sel        (src1_sel),
    .src2_sel        (src2_sel),
    .src3_sel        (src3_sel),
    .vgpr_src1_rd_en (vgpr_src1_rd_en),
    .vgpr_src2_rd_en (vgpr_src2_rd_en),
    .vgpr_src3_rd_en (vgpr_src3_rd_en),
    .vcc_wr_en       (vcc_wr_en),
    .vgpr_wr_en      (vgpr_wr_en),
    .sgpr_wr_en      (sgpr_wr_en)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Random address in region 0 const, 1 VGPR, 2 SGPR, 3 invalid
  function automatic logic [11:0] rand_addr(input int region);
    logic [31:0] r;
    r = $random(seed);
    case (region % 4)
      0: return {2'b00, r[9:0]};
      1: return {2'b10, r[9:0]};
      2: return {3'b110, r[8:0]};
      default:
      begin
        if (r[10])
          return {4'hF, r[7:0]};  // Above the special addresses
        return ({2'b01, r[9:0]} == `ADDR_LITERAL) ? 12'h7FE : {2'b01, r[9:0]};
      end
    endcase
  endfunction

  function automatic logic [11:0] any_addr();
    logic [31:0] r;
    r = $random(seed);
    return rand_addr(int'(r[1:0]));
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("Error: %s expected 0x%0h, got 0x%0h at %0t", name, exp, act, $time);
      err_count++;
    end
  endtask

  task automatic drive_vec(input logic [11:0] a1, input logic [11:0] a2,
                           input logic [11:0] a3, input logic [31:0] word,
                           input logic [11:0] dest);
    @(posedge clk);
    #1;
    src1_addr      = a1;
    src2_addr      = a2;
    src3_addr      = a3;
    opcode         = word;
    sgpr_dest_addr = dest;
    chk_en         = 1'b1;
    vec_count++;
  endtask

  // Lets the last vector be compared before the report line
  task automatic finish_test(input string name, input int err_start, input int vec_start);
    @(posedge clk);
    #1;
    chk_en = 1'b0;
    @(posedge clk);
    #1;
    tests_run++;
    $display("Test %-14s %0d vectors, %0d errors", name, vec_count - vec_start,
             err_count - err_start);
  endtask

  task automatic check_reset_state();
    check_val("src1_sel", SRC_INVALID, src1_sel);
    check_val("src2_sel", SRC_INVALID, src2_sel);
    check_val("src3_sel", SRC_INVALID, src3_sel);
    check_val("vgpr_src1_rd_en", 0, vgpr_src1_rd_en);
    check_val("vgpr_src2_rd_en", 0, vgpr_src2_rd_en);
    check_val("vgpr_src3_rd_en", 0, vgpr_src3_rd_en);
    check_val("vcc_wr_en", 0, vcc_wr_en);
    check_val("vgpr_wr_en", 0, vgpr_wr_en);
    check_val("sgpr_wr_en", 0, sgpr_wr_en);
  endtask

  task automatic compare_outputs(input logic [11:0] a1, input logic [11:0] a2,
                                 input logic [11:0] a3, input logic [31:0] word,
                                 input logic [11:0] dest);
    src_sel_e    e1;
    src_sel_e    e2;
    src_sel_e    e3;
    logic [2:0]  ewr;
    e1  = ref_src_decode(a1);
    e2  = ref_src_decode(a2);
    e3  = ref_src_decode(a3);
    ewr = ref_wr_decode(word, dest);
    check_val("src1_sel", e1, src1_sel);
    check_val("src2_sel", e2, src2_sel);
    check_val("src3_sel", e3, src3_sel);
    check_val("vgpr_src1_rd_en", e1 == SRC_VGPR, vgpr_src1_rd_en);
    check_val("vgpr_src2_rd_en", e2 == SRC_VGPR, vgpr_src2_rd_en);
    check_val("vgpr_src3_rd_en", e3 == SRC_VGPR, vgpr_src3_rd_en);
    check_val("vcc_wr_en", ewr[2], vcc_wr_en);
    check_val("vgpr_wr_en", ewr[1], vgpr_wr_en);
    check_val("sgpr_wr_en", ewr[0], sgpr_wr_en);
  endtask

  // Inputs seen at a rising edge are checked at the following falling edge
  always
  begin
    logic [11:0] p1;
    logic [11:0] p2;
    logic [11:0] p3;
    logic [31:0] pword;
    logic [11:0] pdest;
    logic        pvalid;
    @(posedge clk);
    p1     = src1_addr;
    p2     = src2_addr;
    p3     = src3_addr;
    pword  = opcode;
    pdest  = sgpr_dest_addr;
    pvalid = chk_en && arst_n;
    @(negedge clk);
    if (pvalid)
      compare_outputs(p1, p2, p3, pword, pdest);
  end

  task automatic test_reset();
    int e0;
    int v0;
    e0 = err_count;
    v0 = vec_count;
    #1;
    arst_n = 1'b0;  // Asserted ahead of the first clock edge
    #2;
    check_reset_state();
    repeat (2) @(posedge clk);
    #1;
    check_reset_state();  // Still in reset after edges
    arst_n = 1'b1;
    #2;
    check_reset_state();  // Released before the next edge
    finish_test("reset", e0, v0);
  endtask

  task automatic test_source_addresses();
    int e0;
    int v0;
    e0 = err_count;
    v0 = vec_count;
    for (int i = 0; i < 9; i++)
      drive_vec(SPECIAL_ADDRS[i], SPECIAL_ADDRS[(i + 3) % 9], SPECIAL_ADDRS[(i + 6) % 9],
                32'h0, 12'h000);
    for (int r = 0; r < 4; r++)
      for (int k = 0; k < RAND_PER_REGION; k++)
        drive_vec(rand_addr(r), rand_addr(r + 1), rand_addr(r + 2), 32'h0, 12'h000);
    finish_test("source_addr", e0, v0);
  endtask

  task automatic test_opcode_table();
    int          e0;
    int          v0;
    logic [11:0] cmp_op;
    e0 = err_count;
    v0 = vec_count;
    drive_vec(any_addr(), any_addr(), any_addr(), {`FMT_VOP1, 12'h0, 12'h001}, 12'h000);
    for (int i = 0; i < 12; i++)
      drive_vec(any_addr(), any_addr(), any_addr(), {`FMT_VOP2, 12'h0, VOP2_OPS[i]}, 12'h000);
    for (int i = 0; i < 9; i++)
      drive_vec(any_addr(), any_addr(), any_addr(), {`FMT_VOP3A, 12'h0, VOP3_OPS[i]}, 12'h000);
    for (int k = 0; k < 16; k++)
    begin
      cmp_op = (k < 8) ? 12'h080 + k : 12'h0C0 + k - 8;
      drive_vec(any_addr(), any_addr(), any_addr(), {`FMT_VOPC, 12'h0, cmp_op}, 12'h000);
      drive_vec(any_addr(), any_addr(), any_addr(), {`FMT_VOP3A, 12'h0, cmp_op}, 12'h000);
    end
    finish_test("opcode_table", e0, v0);
  endtask

  task automatic test_vop3a_override();
    int e0;
    int v0;
    e0 = err_count;
    v0 = vec_count;
    for (int d = 0; d < 4; d++)
      for (int w = 0; w < 5; w++)
        drive_vec(any_addr(), any_addr(), any_addr(), OVR_WORDS[w], OVR_DESTS[d]);
    finish_test("vop3a_override", e0, v0);
  endtask

  task automatic test_unknown_words();
    int          e0;
    int          v0;
    logic [31:0] r;
    logic [11:0] dest;
    e0 = err_count;
    v0 = vec_count;
    for (int i = 0; i < 8; i++)
      drive_vec(any_addr(), any_addr(), any_addr(), UNK_WORDS[i], UNK_DESTS[i]);
    for (int i = 0; i < N_UNKNOWN - 8; i++)
    begin
      r    = $random(seed);
      dest = (r[1:0] == 2'd0) ? `ADDR_VCC_LO : rand_addr(int'(r[3:2]));
      drive_vec(any_addr(), any_addr(), any_addr(), $random(seed), dest);
    end
    finish_test("unknown_words", e0, v0);
  endtask

  task automatic test_back_to_back();
    int          e0;
    int          v0;
    logic [31:0] r;
    logic [7:0]  fmt;
    e0 = err_count;
    v0 = vec_count;
    for (int i = 0; i < N_B2B; i++)
    begin
      r   = $random(seed);
      fmt = 8'h01 << r[1:0];  // One of the four known formats
      drive_vec(any_addr(), any_addr(), any_addr(), {fmt, 12'h0, 3'b000, r[10:2]},
                r[11] ? `ADDR_VCC_LO : any_addr());
    end
    finish_test("back_to_back", e0, v0);
  endtask

  initial
  begin
    arst_n         = 1'b1;
    chk_en         = 1'b0;
    src1_addr      = 12'h800;  // VGPR reads if reset were ignored
    src2_addr      = 12'h801;
    src3_addr      = 12'hC00;
    opcode         = {`FMT_VOP2, 12'h0, 12'h025};
    sgpr_dest_addr = 12'h000;
    err_count      = 0;
    vec_count      = 0;
    tests_run      = 0;
    test_reset();
    test_source_addresses();
    test_opcode_table();
    test_vop3a_override();
    test_unknown_words();
    test_back_to_back();
    $display("Tests %0d, vectors %0d, errors %0d", tests_run, vec_count, err_count);
    if (err_count == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  initial
  begin
    #((NUM_VECTORS + 20) * 10);
    $display("Timeout: the tests did not complete in time");
    $display("Finished with errors");
    $finish;
  end

endmodule
